//--- Bender.yml
package:
  name: rv32_core

sources:
  - files:
      - design/rv32_pkg.sv
      - design/rv32_regfile.sv
      - design/rv32_alu.sv
      - design/rv32_decoder.sv
      - design/rv32_mem_port.sv
      - design/rv32_core.sv
  - target: test
    files:
      - tests/rv32_core_checker.sv
      - tests/tb_rv32_core.sv

//--- design/rv32_alu.sv
// rv32_alu: add/sub, logic ops, barrel shifts and the signed and unsigned compares
`timescale 1ns/10ps

module rv32_alu (
	input  logic [rv32_pkg::XLEN-1:0] a,
	input  logic [rv32_pkg::XLEN-1:0] b,
	input  rv32_pkg::alu_op_e         op,
	output logic [rv32_pkg::XLEN-1:0] result,
	output logic                      cmp
);

	logic       eq;
	logic       lts;
	logic       ltu;
	logic [4:0] shamt;

	assign eq    = a == b;
	assign lts   = $signed(a) < $signed(b);
	assign ltu   = a < b;
	assign shamt = b[4:0];

	// branch condition, also the slt/sltu bit
	always_comb begin
		case (op)
			rv32_pkg::ALU_EQ:   cmp = eq;
			rv32_pkg::ALU_NE:   cmp = !eq;
			rv32_pkg::ALU_SLT:  cmp = lts;
			rv32_pkg::ALU_GE:   cmp = !lts;
			rv32_pkg::ALU_SLTU: cmp = ltu;
			rv32_pkg::ALU_GEU:  cmp = !ltu;
			default:            cmp = 1'b0;
		endcase
	end

	always_comb begin
		case (op)
			rv32_pkg::ALU_ADD: result = a + b;
			rv32_pkg::ALU_SUB: result = a - b;
			rv32_pkg::ALU_XOR: result = a ^ b;
			rv32_pkg::ALU_OR:  result = a | b;
			rv32_pkg::ALU_AND: result = a & b;
			rv32_pkg::ALU_SLL: result = a << shamt;
			rv32_pkg::ALU_SRL: result = a >> shamt;
			rv32_pkg::ALU_SRA: result = $signed(a) >>> shamt;
			default:           result = {{(rv32_pkg::XLEN-1){1'b0}}, cmp}; // compares
		endcase
	end

endmodule

//--- design/rv32_core.sv
// rv32_core: main fsm, pc, operand registers, writeback, trap logic and the core sub-blocks
`timescale 1ns/10ps

module rv32_core #(
	parameter logic [rv32_pkg::XLEN-1:0] PROGADDR_RESET = rv32_pkg::PROGADDR_RESET_DEFAULT,
	parameter int NUM_REGS = 32
) (
	input  logic                      clk,
	input  logic                      resetn,
	output logic                      trap,
	output logic                      mem_valid,
	output logic                      mem_instr,
	input  logic                      mem_ready,
	output logic [rv32_pkg::XLEN-1:0] mem_addr,
	output logic [rv32_pkg::XLEN-1:0] mem_wdata,
	output logic [3:0]                mem_wstrb,
	input  logic [rv32_pkg::XLEN-1:0] mem_rdata
);

	localparam int XLEN = rv32_pkg::XLEN;
	localparam int IW   = $clog2(NUM_REGS);

	rv32_pkg::cpu_state_e cpu_state;
	logic [XLEN-1:0]      pc;
	logic [XLEN-1:0]      op1;
	logic [XLEN-1:0]      op2;
	logic [XLEN-1:0]      wb_data; // result written back at the next fetch
	logic [IW-1:0]        wb_rd;
	logic                 wb_en;
	logic                 req_sent; // this state's memory request is out

	logic                 dec_valid;
	logic [IW-1:0]        rd;
	logic [IW-1:0]        rs1;
	logic [IW-1:0]        rs2;
	logic [XLEN-1:0]      imm;
	rv32_pkg::alu_op_e    alu_op;
	rv32_pkg::mem_size_e  mem_size;
	logic                 load_unsigned;
	logic                 is_lui;
	logic                 is_auipc;
	logic                 is_jal;
	logic                 is_jalr;
	logic                 is_branch;
	logic                 is_load;
	logic                 is_store;
	logic                 is_alu_imm;
	logic                 is_illegal;

	logic [XLEN-1:0]      rs1_val;
	logic [XLEN-1:0]      rs2_val;
	logic [XLEN-1:0]      alu_result;
	logic                 cmp;
	logic [XLEN-1:0]      pc_plus4;
	logic [XLEN-1:0]      pc_branch;
	logic [XLEN-1:0]      eff_addr;
	logic [XLEN-1:0]      req_addr;
	rv32_pkg::mem_size_e  req_size;
	logic                 misalign;
	logic                 use_imm;
	logic                 do_rinst;
	logic                 do_rdata;
	logic                 do_wdata;
	logic                 mem_done;
	logic                 fetch_done;
	logic [XLEN-1:0]      rdata_word;
	logic                 rf_we;

	assign trap      = cpu_state == rv32_pkg::CPU_TRAP;
	assign pc_plus4  = pc + 32'd4;
	assign pc_branch = pc + imm;
	assign eff_addr  = op1 + imm; // load/store address
	assign use_imm   = is_lui || is_auipc || is_jal || is_jalr || is_alu_imm;
	assign misalign  = (mem_size == rv32_pkg::SIZE_WORD && eff_addr[1:0] != 2'b00) ||
		(mem_size == rv32_pkg::SIZE_HALF && eff_addr[0]);

	// single-cycle request pulses
	assign do_rinst = cpu_state == rv32_pkg::CPU_FETCH && !req_sent && pc[1:0] == 2'b00;
	assign do_wdata = cpu_state == rv32_pkg::CPU_STMEM && !req_sent && !misalign;
	assign do_rdata = cpu_state == rv32_pkg::CPU_LDMEM && !req_sent && !misalign;
	assign req_addr = (cpu_state == rv32_pkg::CPU_FETCH) ? pc : eff_addr;
	assign req_size = (cpu_state == rv32_pkg::CPU_FETCH) ? rv32_pkg::SIZE_WORD : mem_size;

	assign fetch_done = mem_done && cpu_state == rv32_pkg::CPU_FETCH;
	assign rf_we      = cpu_state == rv32_pkg::CPU_FETCH && !req_sent && wb_en; // previous result

	rv32_mem_port i_mem_port (
		.clk(clk), .resetn(resetn), .trap(trap),
		.do_rinst(do_rinst), .do_rdata(do_rdata), .do_wdata(do_wdata),
		.addr(req_addr), .wdata(op2), .size(req_size),
		.mem_done(mem_done), .rdata_word(rdata_word),
		.mem_valid(mem_valid), .mem_instr(mem_instr), .mem_ready(mem_ready),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
		.mem_rdata(mem_rdata)
	);

	rv32_decoder #(
		.NUM_REGS(NUM_REGS)
	) i_decoder (
		.clk(clk), .resetn(resetn), .fetch_done(fetch_done), .instr(mem_rdata),
		.dec_valid(dec_valid), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm),
		.alu_op(alu_op), .mem_size(mem_size), .load_unsigned(load_unsigned),
		.is_lui(is_lui), .is_auipc(is_auipc), .is_jal(is_jal), .is_jalr(is_jalr),
		.is_branch(is_branch), .is_load(is_load), .is_store(is_store),
		.is_alu_imm(is_alu_imm), .is_illegal(is_illegal)
	);

	rv32_alu i_alu (
		.a(op1), .b(op2), .op(alu_op), .result(alu_result), .cmp(cmp)
	);

	rv32_regfile #(
		.NUM_REGS(NUM_REGS)
	) i_regfile (
		.clk(clk), .we(rf_we), .waddr(wb_rd), .raddr1(rs1), .raddr2(rs2),
		.wdata(wb_data), .rdata1(rs1_val), .rdata2(rs2_val)
	);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			cpu_state <= rv32_pkg::CPU_FETCH;
			pc        <= PROGADDR_RESET;
			req_sent  <= 1'b0;
			wb_en     <= 1'b0;
		end else begin
			case (cpu_state)
				rv32_pkg::CPU_FETCH: begin
					if (!req_sent) begin
						wb_en <= 1'b0;
						if (pc[1:0] != 2'b00) begin // misaligned fetch
							cpu_state <= rv32_pkg::CPU_TRAP;
						end else begin
							req_sent <= 1'b1;
						end
					end else if (dec_valid) begin
						req_sent  <= 1'b0;
						cpu_state <= rv32_pkg::CPU_LD_RS;
					end
				end
				rv32_pkg::CPU_LD_RS: begin
					op1   <= is_lui ? '0 : (is_auipc || is_jal) ? pc : rs1_val;
					op2   <= use_imm ? imm : rs2_val;
					wb_rd <= rd;
					if (is_illegal) begin
						cpu_state <= rv32_pkg::CPU_TRAP;
					end else if (is_load) begin
						cpu_state <= rv32_pkg::CPU_LDMEM;
					end else if (is_store) begin
						cpu_state <= rv32_pkg::CPU_STMEM;
					end else begin
						cpu_state <= rv32_pkg::CPU_EXEC;
					end
				end
				rv32_pkg::CPU_EXEC: begin
					cpu_state <= rv32_pkg::CPU_FETCH;
					if (is_branch) begin
						pc <= cmp ? pc_branch : pc_plus4; // nothing written back
					end else if (is_jal || is_jalr) begin
						pc      <= {alu_result[XLEN-1:1], 1'b0};
						wb_data <= pc_plus4; // link
						wb_en   <= 1'b1;
					end else begin
						pc      <= pc_plus4;
						wb_data <= alu_result;
						wb_en   <= 1'b1;
					end
				end
				rv32_pkg::CPU_STMEM: begin
					if (!req_sent) begin
						if (misalign) begin
							cpu_state <= rv32_pkg::CPU_TRAP;
						end else begin
							req_sent <= 1'b1;
						end
					end else if (mem_done) begin
						req_sent  <= 1'b0;
						pc        <= pc_plus4;
						cpu_state <= rv32_pkg::CPU_FETCH;
					end
				end
				rv32_pkg::CPU_LDMEM: begin
					if (!req_sent) begin
						if (misalign) begin
							cpu_state <= rv32_pkg::CPU_TRAP;
						end else begin
							req_sent <= 1'b1;
						end
					end else if (mem_done) begin
						// rdata_word comes zero-extended, sign only for lb and lh
						if (mem_size == rv32_pkg::SIZE_BYTE && !load_unsigned) begin
							wb_data <= {{24{rdata_word[7]}}, rdata_word[7:0]};
						end else if (mem_size == rv32_pkg::SIZE_HALF && !load_unsigned) begin
							wb_data <= {{16{rdata_word[15]}}, rdata_word[15:0]};
						end else begin
							wb_data <= rdata_word;
						end
						wb_en     <= 1'b1;
						req_sent  <= 1'b0;
						pc        <= pc_plus4;
						cpu_state <= rv32_pkg::CPU_FETCH;
					end
				end
				rv32_pkg::CPU_TRAP: begin
					cpu_state <= rv32_pkg::CPU_TRAP; // held until reset
				end
				default: cpu_state <= rv32_pkg::CPU_TRAP;
			endcase
		end
	end

endmodule

//--- design/rv32_decoder.sv
// rv32_decoder: two-stage decode into register indices, immediate, alu op, access size and class
`timescale 1ns/10ps

module rv32_decoder #(
	parameter int NUM_REGS = 32
) (
	input  logic                        clk,
	input  logic                        resetn,
	input  logic                        fetch_done,
	input  logic [rv32_pkg::XLEN-1:0]   instr,
	output logic                        dec_valid,
	output logic [$clog2(NUM_REGS)-1:0] rd,
	output logic [$clog2(NUM_REGS)-1:0] rs1,
	output logic [$clog2(NUM_REGS)-1:0] rs2,
	output logic [rv32_pkg::XLEN-1:0]   imm,
	output rv32_pkg::alu_op_e           alu_op,
	output rv32_pkg::mem_size_e         mem_size,
	output logic                        load_unsigned,
	output logic                        is_lui,
	output logic                        is_auipc,
	output logic                        is_jal,
	output logic                        is_jalr,
	output logic                        is_branch,
	output logic                        is_load,
	output logic                        is_store,
	output logic                        is_alu_imm,
	output logic                        is_illegal
);

	localparam int IW = $clog2(NUM_REGS);

	logic [rv32_pkg::XLEN-1:0] instr_q;
	logic                      is_alu_reg;
	logic [2:0]                funct3;
	logic [6:0]                funct7;
	logic                      f7_ok;

	always_ff @(posedge clk) begin
		if (fetch_done) begin
			instr_q <= instr;
		end
	end

	// stage one, major opcode class
	always_ff @(posedge clk) begin
		if (!resetn) begin
			dec_valid  <= 1'b0;
			is_lui     <= 1'b0;
			is_auipc   <= 1'b0;
			is_jal     <= 1'b0;
			is_jalr    <= 1'b0;
			is_branch  <= 1'b0;
			is_load    <= 1'b0;
			is_store   <= 1'b0;
			is_alu_imm <= 1'b0;
			is_alu_reg <= 1'b0;
		end else begin
			dec_valid <= fetch_done; // stage two is ready one cycle on
			if (fetch_done) begin
				is_lui     <= instr[6:0] == rv32_pkg::OPC_LUI;
				is_auipc   <= instr[6:0] == rv32_pkg::OPC_AUIPC;
				is_jal     <= instr[6:0] == rv32_pkg::OPC_JAL;
				is_jalr    <= instr[6:0] == rv32_pkg::OPC_JALR;
				is_branch  <= instr[6:0] == rv32_pkg::OPC_BRANCH;
				is_load    <= instr[6:0] == rv32_pkg::OPC_LOAD;
				is_store   <= instr[6:0] == rv32_pkg::OPC_STORE;
				is_alu_imm <= instr[6:0] == rv32_pkg::OPC_OP_IMM;
				is_alu_reg <= instr[6:0] == rv32_pkg::OPC_OP;
			end
		end
	end

	assign rd     = instr_q[7 +: IW];
	assign rs1    = instr_q[15 +: IW];
	assign rs2    = instr_q[20 +: IW];
	assign funct3 = instr_q[14:12];
	assign funct7 = instr_q[31:25];

	// alternate encoding only for sub, sra and srai
	assign f7_ok = funct7 == 7'b0000000 ||
		(funct7 == 7'b0100000 && (funct3 == 3'b101 || (is_alu_reg && funct3 == 3'b000)));

	// stage two, funct fields and immediate
	always_comb begin
		imm           = '0;
		alu_op        = rv32_pkg::ALU_ADD;
		mem_size      = rv32_pkg::SIZE_WORD;
		load_unsigned = 1'b0;
		is_illegal    = 1'b0;
		case (1'b1)
			is_lui, is_auipc: imm = {instr_q[31:12], 12'b0};
			is_jal: imm = {{12{instr_q[31]}}, instr_q[19:12], instr_q[20], instr_q[30:21], 1'b0};
			is_jalr: begin
				imm        = {{20{instr_q[31]}}, instr_q[31:20]};
				is_illegal = funct3 != 3'b000;
			end
			is_branch: begin
				imm = {{20{instr_q[31]}}, instr_q[7], instr_q[30:25], instr_q[11:8], 1'b0};
				case (funct3)
					3'b000:  alu_op = rv32_pkg::ALU_EQ;
					3'b001:  alu_op = rv32_pkg::ALU_NE;
					3'b100:  alu_op = rv32_pkg::ALU_SLT;
					3'b101:  alu_op = rv32_pkg::ALU_GE;
					3'b110:  alu_op = rv32_pkg::ALU_SLTU;
					3'b111:  alu_op = rv32_pkg::ALU_GEU;
					default: is_illegal = 1'b1;
				endcase
			end
			is_load: begin
				imm           = {{20{instr_q[31]}}, instr_q[31:20]};
				load_unsigned = funct3[2]; // lbu, lhu
				case (funct3)
					3'b000, 3'b100: mem_size = rv32_pkg::SIZE_BYTE;
					3'b001, 3'b101: mem_size = rv32_pkg::SIZE_HALF;
					3'b010:         mem_size = rv32_pkg::SIZE_WORD;
					default:        is_illegal = 1'b1;
				endcase
			end
			is_store: begin
				imm = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
				case (funct3)
					3'b000:  mem_size = rv32_pkg::SIZE_BYTE;
					3'b001:  mem_size = rv32_pkg::SIZE_HALF;
					3'b010:  mem_size = rv32_pkg::SIZE_WORD;
					default: is_illegal = 1'b1;
				endcase
			end
			is_alu_imm, is_alu_reg: begin
				if (is_alu_imm) begin
					imm = {{20{instr_q[31]}}, instr_q[31:20]}; // shamt sits in imm[4:0]
				end
				case (funct3)
					3'b000:  alu_op = (is_alu_reg && funct7[5]) ? rv32_pkg::ALU_SUB
						: rv32_pkg::ALU_ADD;
					3'b001:  alu_op = rv32_pkg::ALU_SLL;
					3'b010:  alu_op = rv32_pkg::ALU_SLT;
					3'b011:  alu_op = rv32_pkg::ALU_SLTU;
					3'b100:  alu_op = rv32_pkg::ALU_XOR;
					3'b101:  alu_op = funct7[5] ? rv32_pkg::ALU_SRA : rv32_pkg::ALU_SRL;
					3'b110:  alu_op = rv32_pkg::ALU_OR;
					default: alu_op = rv32_pkg::ALU_AND;
				endcase
				is_illegal = (is_alu_reg || funct3 == 3'b001 || funct3 == 3'b101) && !f7_ok;
			end
			default: is_illegal = 1'b1; // unknown opcode, ecall, ebreak
		endcase
	end

endmodule

//--- design/rv32_mem_port.sv
// rv32_mem_port: valid/ready request fsm with write lane packing and read lane extraction
`timescale 1ns/10ps

module rv32_mem_port (
	input  logic                      clk,
	input  logic                      resetn,
	input  logic                      trap,
	input  logic                      do_rinst,
	input  logic                      do_rdata,
	input  logic                      do_wdata,
	input  logic [rv32_pkg::XLEN-1:0] addr,
	input  logic [rv32_pkg::XLEN-1:0] wdata,
	input  rv32_pkg::mem_size_e       size,
	output logic                      mem_done,
	output logic [rv32_pkg::XLEN-1:0] rdata_word,
	output logic                      mem_valid,
	output logic                      mem_instr,
	input  logic                      mem_ready,
	output logic [rv32_pkg::XLEN-1:0] mem_addr,
	output logic [rv32_pkg::XLEN-1:0] mem_wdata,
	output logic [3:0]                mem_wstrb,
	input  logic [rv32_pkg::XLEN-1:0] mem_rdata
);

	rv32_pkg::mem_state_e      mem_state;
	rv32_pkg::mem_size_e       size_q; // size and lane of the access in flight
	logic [1:0]                lane_q;
	logic [rv32_pkg::XLEN-1:0] lane_wdata;
	logic [3:0]                lane_wstrb;

	// store data copied to every lane, strobes pick the addressed one
	always_comb begin
		case (size)
			rv32_pkg::SIZE_HALF: begin
				lane_wdata = {2{wdata[15:0]}};
				lane_wstrb = addr[1] ? 4'b1100 : 4'b0011;
			end
			rv32_pkg::SIZE_BYTE: begin
				lane_wdata = {4{wdata[7:0]}};
				lane_wstrb = 4'b0001 << addr[1:0];
			end
			default: begin
				lane_wdata = wdata;
				lane_wstrb = 4'b1111;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			mem_state <= rv32_pkg::MEM_IDLE;
			mem_valid <= 1'b0;
		end else begin
			case (mem_state)
				rv32_pkg::MEM_IDLE: begin
					if (!trap && (do_rinst || do_rdata)) begin
						mem_valid <= 1'b1;
						mem_state <= rv32_pkg::MEM_READ;
					end else if (!trap && do_wdata) begin
						mem_valid <= 1'b1;
						mem_state <= rv32_pkg::MEM_WRITE;
					end
				end
				rv32_pkg::MEM_READ, rv32_pkg::MEM_WRITE: begin
					if (mem_ready) begin // transfer edge
						mem_valid <= 1'b0;
						mem_state <= rv32_pkg::MEM_IDLE;
					end
				end
				default: mem_state <= rv32_pkg::MEM_IDLE;
			endcase
		end
	end

	// request fields, only loaded in idle so they hold until the transfer
	always_ff @(posedge clk) begin
		if (mem_state == rv32_pkg::MEM_IDLE && (do_rinst || do_rdata || do_wdata)) begin
			mem_addr  <= {addr[rv32_pkg::XLEN-1:2], 2'b00};
			mem_wdata <= lane_wdata;
			mem_wstrb <= do_wdata ? lane_wstrb : 4'b0000;
			mem_instr <= do_rinst;
			size_q    <= size;
			lane_q    <= addr[1:0];
		end
	end

	assign mem_done = mem_valid && mem_ready;

	// addressed lane shifted down, zero-extended
	always_comb begin
		case (size_q)
			rv32_pkg::SIZE_HALF: rdata_word = {16'b0, lane_q[1] ? mem_rdata[31:16] : mem_rdata[15:0]};
			rv32_pkg::SIZE_BYTE: rdata_word = {24'b0, mem_rdata[{lane_q, 3'b000} +: 8]};
			default:             rdata_word = mem_rdata;
		endcase
	end

endmodule

//--- design/rv32_pkg.sv
// rv32_pkg: data width, reset address, rv32i opcodes and the fsm, alu and access size enums
package rv32_pkg;

	localparam int XLEN = 32;

	// default fetch address after reset
	localparam logic [XLEN-1:0] PROGADDR_RESET_DEFAULT = 32'h0000_0000;

	// rv32i major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLT,  // also blt
		ALU_SLTU, // also bltu
		ALU_EQ,
		ALU_NE,
		ALU_GE,
		ALU_GEU
	} alu_op_e;

	typedef enum logic [2:0] {
		CPU_TRAP,
		CPU_FETCH,
		CPU_LD_RS,
		CPU_EXEC,
		CPU_STMEM,
		CPU_LDMEM
	} cpu_state_e;

	typedef enum logic [1:0] {
		MEM_IDLE,
		MEM_READ,
		MEM_WRITE
	} mem_state_e;

	// same order as the reference wordsize code
	typedef enum logic [1:0] {
		SIZE_WORD,
		SIZE_HALF,
		SIZE_BYTE
	} mem_size_e;

endpackage

//--- design/rv32_regfile.sv
// rv32_regfile: integer register file, two asynchronous read ports and one write port
`timescale 1ns/10ps

module rv32_regfile #(
	parameter int NUM_REGS = 32
) (
	input  logic                          clk,
	input  logic                          we,
	input  logic [$clog2(NUM_REGS)-1:0]   waddr,
	input  logic [$clog2(NUM_REGS)-1:0]   raddr1,
	input  logic [$clog2(NUM_REGS)-1:0]   raddr2,
	input  logic [rv32_pkg::XLEN-1:0]     wdata,
	output logic [rv32_pkg::XLEN-1:0]     rdata1,
	output logic [rv32_pkg::XLEN-1:0]     rdata2
);

	logic [rv32_pkg::XLEN-1:0] regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (we && waddr != '0) begin // x0 is never written
			regs[waddr] <= wdata;
		end
	end

	// x0 reads as zero
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- filelist.f
design/rv32_pkg.sv
design/rv32_regfile.sv
design/rv32_alu.sv
design/rv32_decoder.sv
design/rv32_mem_port.sv
design/rv32_core.sv
tests/rv32_core_checker.sv
tests/tb_rv32_core.sv

//--- tests/rv32_core_checker.sv
// rv32_core_checker: memory handshake, reset and trap assertions, bound into rv32_core
`timescale 1ns/10ps

module rv32_core_checker (
	input logic                 clk,
	input logic                 resetn,
	input logic                 trap,
	input logic                 mem_valid,
	input logic                 mem_instr,
	input logic                 mem_ready,
	input logic [31:0]          mem_addr,
	input logic [31:0]          mem_wdata,
	input logic [3:0]           mem_wstrb,
	input rv32_pkg::cpu_state_e cpu_state
);

	int unsigned fail_count;

	initial fail_count = 0;

	// request held until the transfer edge
	a_req_stable: assert property (@(posedge clk) disable iff (!resetn)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_wdata)
			&& $stable(mem_wstrb) && $stable(mem_instr))
	else begin
		$error("memory request changed before mem_ready");
		fail_count++;
	end

	a_read_wstrb: assert property (@(posedge clk) disable iff (!resetn)
		mem_valid && cpu_state != rv32_pkg::CPU_STMEM |-> mem_wstrb == 4'b0000)
	else begin
		$error("read request with nonzero wstrb");
		fail_count++;
	end

	a_instr_no_store: assert property (@(posedge clk) disable iff (!resetn)
		mem_valid && mem_instr |-> mem_wstrb == 4'b0000)
	else begin
		$error("write strobes set on an instruction fetch");
		fail_count++;
	end

	a_reset_quiet: assert property (@(posedge clk) !resetn |=> !trap && !mem_valid)
	else begin
		$error("trap or mem_valid high after reset");
		fail_count++;
	end

	// trap is a level, no requests once in it
	a_trap_quiet: assert property (@(posedge clk) disable iff (!resetn)
		trap |-> !mem_valid ##1 trap)
	else begin
		$error("request raised or trap dropped while trapped");
		fail_count++;
	end

endmodule

bind rv32_core rv32_core_checker i_checker (
	.clk(clk), .resetn(resetn), .trap(trap),
	.mem_valid(mem_valid), .mem_instr(mem_instr), .mem_ready(mem_ready),
	.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
	.cpu_state(cpu_state)
);

//--- tests/tb_rv32_core.sv
// testbench top with clock, reset, wait-state memory, program image, bus monitor and watchdog
`timescale 1ns/10ps

module tb_rv32_core;

	localparam logic [31:0] PROG_BASE   = rv32_pkg::PROGADDR_RESET_DEFAULT;
	localparam logic [31:0] SIG_BASE    = PROG_BASE + 32'h600; // result signature area
	localparam logic [31:0] DATA_BASE   = PROG_BASE + 32'hf00; // word read by the load tests
	localparam int          MEM_WORDS   = 1024;
	localparam int          BASE_CYCLES = 2000; // about 110 instructions of under 18 cycles each
	localparam int          WAIT_FACTOR = 4;    // mem_ready is high half the time on average

	logic        clk;
	logic        resetn;
	logic        trap;
	logic        mem_valid;
	logic        mem_instr;
	logic        mem_ready;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [3:0]  mem_wstrb;
	logic [31:0] mem_rdata;

	logic [31:0] mem [MEM_WORDS];
	logic [31:0] next_fetch [MEM_WORDS]; // expected pc after the instruction in each word
	logic [31:0] lfsr;
	logic [31:0] pc;      // program builder position
	logic [31:0] sig_off;
	logic [31:0] exp_fetch;
	logic [31:0] store_word;
	logic        seen_req;
	logic [31:0] exp_addr_q [$];
	logic [31:0] exp_data_q [$];
	logic [3:0]  exp_strb_q [$];
	string       exp_name_q [$];

	rv32_core #(
		.PROGADDR_RESET(PROG_BASE),
		.NUM_REGS(32)
	) i_rv32_core (
		.clk(clk), .resetn(resetn), .trap(trap),
		.mem_valid(mem_valid), .mem_instr(mem_instr), .mem_ready(mem_ready),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
		.mem_rdata(mem_rdata)
	);

	initial clk = 1'b0;
	always #50 clk = !clk;

	task automatic report_failure(string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
		assert (act === exp) else
			report_failure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic lfsr_bit();
		lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
		return lfsr[0];
	endfunction

	function automatic logic [31:0] lfsr_word();
		logic [31:0] w;
		w = '0;
		for (int i = 0; i < 32; i++) begin
			w = {w[30:0], lfsr_bit()};
		end
		return w;
	endfunction

	function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], rv32_pkg::OPC_STORE};
	endfunction

	function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv32_pkg::OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv32_pkg::OPC_JAL};
	endfunction

	// rv32i result of an OP instruction with alt selecting sub or sra
	function automatic logic [31:0] alu_model(logic [2:0] f3, logic alt, logic [31:0] a,
		logic [31:0] b);
		logic signed [31:0] sa;
		sa = a;
		case (f3)
			3'd0:    return alt ? a - b : a + b;
			3'd1:    return a << b[4:0];
			3'd2:    return {31'b0, sa < $signed(b)};
			3'd3:    return {31'b0, a < b};
			3'd4:    return a ^ b;
			3'd5: begin
				if (alt) begin
					return sa >>> b[4:0];
				end else begin
					return a >> b[4:0];
				end
			end
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic put(logic [31:0] instr, logic [31:0] next);
		mem[pc[11:2]]        = instr;
		next_fetch[pc[11:2]] = next;
		pc                   = pc + 4;
	endtask

	task automatic put_seq(logic [31:0] instr);
		put(instr, pc + 4);
	endtask

	task automatic load_const(logic [4:0] rd, logic [31:0] v);
		logic [31:0] hi;
		hi = v + 32'h800; // addi sign-extends the low part
		put_seq({hi[31:12], rd, rv32_pkg::OPC_LUI});
		put_seq(enc_i(v[11:0], rd, 3'b000, rd, rv32_pkg::OPC_OP_IMM));
	endtask

	task automatic expect_store(logic [31:0] addr, logic [31:0] data, logic [3:0] strb,
		string name);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back(data);
		exp_strb_q.push_back(strb);
		exp_name_q.push_back(name);
	endtask

	task automatic store_result(logic [4:0] rs, logic [31:0] exp, string name);
		put_seq(enc_s(sig_off[11:0], rs, 5'd31, 3'b010));
		expect_store(SIG_BASE + sig_off, exp, 4'b1111, name);
		sig_off = sig_off + 4;
	endtask

	task automatic build_alu_tests();
		logic [31:0] a;
		logic [31:0] b;
		logic [2:0]  f3;
		logic        alt;
		for (int round = 0; round < 2; round++) begin
			a = lfsr_word();
			b = lfsr_word();
			load_const(5'd1, a);
			load_const(5'd2, b);
			for (int k = 0; k < 10; k++) begin
				alt = k >= 8; // sub and sra
				f3  = (k == 8) ? 3'd0 : (k == 9) ? 3'd5 : k[2:0];
				put_seq({alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3, rv32_pkg::OPC_OP});
				store_result(5'd3, alu_model(f3, alt, a, b),
					$sformatf("alu f3=%0d alt=%0d round %0d", f3, alt, round));
			end
		end
	endtask

	task automatic build_store_tests();
		logic [31:0] v;
		v = lfsr_word();
		load_const(5'd4, v);
		for (int k = 0; k < 4; k++) begin
			put_seq(enc_s(sig_off[11:0] + k[11:0], 5'd4, 5'd31, 3'b000));
			expect_store(SIG_BASE + sig_off, {4{v[7:0]}}, 4'b0001 << k,
				$sformatf("sb lane %0d", k));
		end
		sig_off = sig_off + 4;
		for (int k = 0; k < 2; k++) begin
			put_seq(enc_s(sig_off[11:0] + {k[10:0], 1'b0}, 5'd4, 5'd31, 3'b001));
			expect_store(SIG_BASE + sig_off, {2{v[15:0]}}, 4'b0011 << (2 * k),
				$sformatf("sh half %0d", k));
		end
		sig_off = sig_off + 4;
		store_result(5'd4, v, "sw");
	endtask

	task automatic build_load_tests();
		logic [31:0] w;
		logic [7:0]  b8;
		logic [15:0] h16;
		w = lfsr_word() | 32'h8000_8000; // both halves negative
		mem[DATA_BASE[11:2]] = w;
		load_const(5'd6, DATA_BASE);
		for (int k = 0; k < 4; k++) begin
			b8 = w[8 * k +: 8];
			put_seq(enc_i(k[11:0], 5'd6, 3'b000, 5'd7, rv32_pkg::OPC_LOAD));
			store_result(5'd7, {{24{b8[7]}}, b8}, $sformatf("lb lane %0d", k));
			put_seq(enc_i(k[11:0], 5'd6, 3'b100, 5'd7, rv32_pkg::OPC_LOAD));
			store_result(5'd7, {24'b0, b8}, $sformatf("lbu lane %0d", k));
		end
		for (int k = 0; k < 2; k++) begin
			h16 = w[16 * k +: 16];
			put_seq(enc_i({k[10:0], 1'b0}, 5'd6, 3'b001, 5'd7, rv32_pkg::OPC_LOAD));
			store_result(5'd7, {{16{h16[15]}}, h16}, $sformatf("lh half %0d", k));
			put_seq(enc_i({k[10:0], 1'b0}, 5'd6, 3'b101, 5'd7, rv32_pkg::OPC_LOAD));
			store_result(5'd7, {16'b0, h16}, $sformatf("lhu half %0d", k));
		end
		put_seq(enc_i(12'd0, 5'd6, 3'b010, 5'd7, rv32_pkg::OPC_LOAD));
		store_result(5'd7, w, "lw");
	endtask

	task automatic build_flow_tests();
		logic [31:0] v;
		logic [31:0] target;
		v = lfsr_word();
		load_const(5'd8, v);
		put(enc_b(13'd8, 5'd8, 5'd8, 3'b000), pc + 8); // beq taken
		put_seq(enc_s(12'h7f0, 5'd0, 5'd0, 3'b010));  // skipped
		put_seq(enc_b(13'd8, 5'd8, 5'd8, 3'b001));     // bne not taken
		store_result(5'd8, v, "bne fall-through");
		target = pc + 4;
		put(enc_j(21'd8, 5'd10), pc + 8);
		put_seq(enc_s(12'h7f4, 5'd0, 5'd0, 3'b010));
		store_result(5'd10, target, "jal link");
		target = pc + 16; // past lui, addi, jalr and the skipped store
		load_const(5'd11, target - 4);
		put(enc_i(12'd4, 5'd11, 3'b000, 5'd12, rv32_pkg::OPC_JALR), target);
		put_seq(enc_s(12'h7f8, 5'd0, 5'd0, 3'b010));
		store_result(5'd12, target - 4, "jalr link");
	endtask

	// memory outputs and wait states
	always @(posedge clk) begin
		#1;
		mem_ready <= lfsr_bit();
		mem_rdata <= mem[mem_addr[11:2]];
	end

	// transfer monitor
	always @(posedge clk) begin
		if (resetn && mem_valid && mem_ready) begin
			if (!seen_req) begin
				check_value("first request is a fetch", 32'd1, {31'b0, mem_instr});
			end
			seen_req = 1'b1;
			if (mem_instr) begin
				check_value("fetch address", exp_fetch, mem_addr);
				exp_fetch = next_fetch[mem_addr[11:2]];
			end else if (mem_wstrb != 4'b0000) begin
				if (exp_addr_q.size() == 0) begin
					report_failure($sformatf("store to %h when no store was expected", mem_addr));
				end else begin
					check_value($sformatf("%s addr", exp_name_q[0]), exp_addr_q[0], mem_addr);
					check_value($sformatf("%s wdata", exp_name_q[0]), exp_data_q[0], mem_wdata);
					check_value($sformatf("%s wstrb", exp_name_q[0]), exp_strb_q[0], mem_wstrb);
					void'(exp_addr_q.pop_front());
					void'(exp_data_q.pop_front());
					void'(exp_strb_q.pop_front());
					void'(exp_name_q.pop_front());
					store_word = mem[mem_addr[11:2]];
					for (int k = 0; k < 4; k++) begin
						if (mem_wstrb[k]) begin
							store_word[8 * k +: 8] = mem_wdata[8 * k +: 8];
						end
					end
					mem[mem_addr[11:2]] <= store_word;
				end
			end
		end
	end

	always @(i_rv32_core.i_checker.fail_count) begin
		if (i_rv32_core.i_checker.fail_count != 0) begin
			report_failure("a bound checker assertion failed");
		end
	end

	initial begin
		repeat (BASE_CYCLES * WAIT_FACTOR) @(posedge clk);
		report_failure("watchdog expired before the program reached its trap");
	end

	initial begin
		resetn    = 1'b0;
		mem_ready = 1'b0;
		mem_rdata = '0;
		lfsr      = 32'hd62ba087;
		pc        = PROG_BASE;
		sig_off   = '0;
		exp_fetch = PROG_BASE;
		seen_req  = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i]        = 32'hbad0_0000 | (i << 2);
			next_fetch[i] = '0;
		end
		load_const(5'd31, SIG_BASE);
		build_alu_tests();
		build_store_tests();
		build_load_tests();
		build_flow_tests();
		put_seq(32'h0000_0073); // ecall is illegal here
		repeat (4) @(posedge clk);
		#1;
		resetn = 1'b1;
		while (!trap) @(negedge clk);
		repeat (20) begin // core stays quiet once trapped
			@(negedge clk);
			assert (!mem_valid) else report_failure("mem_valid went high after trap");
		end
		if (exp_addr_q.size() != 0 || i_rv32_core.i_checker.fail_count != 0) begin
			report_failure($sformatf("%0d expected stores never happened, %0d checker failures",
				exp_addr_q.size(), i_rv32_core.i_checker.fail_count));
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule
